/* sources.f */
+incdir+dv
common/nn_pkg.sv
common/neuron_bus_if.sv
rtl/layer_sequencer.sv
neuron/neuron_mac.sv
rtl/output_collector.sv
rtl/nn_forward.sv
dv/nn_forward_tb.sv

/* dv/nn_vectors.svh */
`ifndef NN_VECTORS_SVH
`define NN_VECTORS_SVH

// Weight source of a command
localparam int w_ident = 0;
localparam int w_rand  = 1;
localparam int w_big   = 2;

localparam int num_cmd  = 6;
localparam int cmd_cols = 12;

// Each row holds layer, act (0 linear, 1 relu), weight source,
// listed expected (1) or reference model (0), second start while busy,
// then input elements 0 to 6
int cmd_table [num_cmd][cmd_cols] = '{
    '{0, 0, w_ident, 1, 0,   10,  -20,  255, -256,    0,    1,   -1},
    '{0, 1, w_rand,  0, 0,  100,  -50,   30, -200,   77,    5, -128},
    '{1, 0, w_rand,  0, 0,    0,    0,    0,    0,    0,    0,    0},
    '{1, 1, w_rand,  0, 0,    0,    0,    0,    0,    0,    0,    0},
    '{0, 0, w_big,   1, 0,  128,  128,  128,  128,  128,  128,  128},
    '{0, 1, w_big,   1, 1,  128,  128,  128,  128,  128,  128,  128}
};

// Expected outputs for rows with a listed result
int exp_table [num_cmd][num_neuron] = '{
    '{  10,  -20,  255, -256,    0,    1,   -1},
    '{   0,    0,    0,    0,    0,    0,    0},
    '{   0,    0,    0,    0,    0,    0,    0},
    '{   0,    0,    0,    0,    0,    0,    0},
    '{ 255, -256,  255, -256,  255, -256,  255},
    '{ 255,    0,  255,    0,  255,    0,  255}
};

`endif

/* dv/nn_forward_tb.sv */
module nn_forward_tb;
    import nn_pkg::*;

    `include "nn_vectors.svh"

    localparam int valid_timeout = 20;
    localparam int latency       = 9;

    logic                                     clk;
    logic                                     arst_n;
    logic                                     start;
    logic [layer_w-1:0]                       layer_number;
    act_e                                     act;
    data_t [num_neuron-1:0]                   start_input;
    weight_t [num_neuron-1:0][num_neuron-1:0] weights;
    logic                                     busy;
    data_t [num_neuron-1:0]                   final_output;
    logic                                     final_output_valid;

    logic [31:0]                              rng;
    weight_t [num_neuron-1:0][num_neuron-1:0] w_mat;
    // Reference copy of the previous layer result
    data_t [num_neuron-1:0]                   model_fb;

    nn_forward u_dut (
        .clk                (clk),
        .arst_n             (arst_n),
        .start              (start),
        .layer_number       (layer_number),
        .act                (act),
        .start_input        (start_input),
        .weights            (weights),
        .busy               (busy),
        .final_output       (final_output),
        .final_output_valid (final_output_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // One neuron, rescale then saturate then activation
    function automatic data_t model_neuron(input weight_t [num_neuron-1:0] row,
                                           input data_t [num_neuron-1:0] src,
                                           input act_e a);
        longint sum;
        longint lim;
        int     j;
        sum = 0;
        lim = longint'(2) ** (data_w - 1);
        for (j = 0; j < num_neuron; j++) begin
            sum = sum + longint'(src[j]) * longint'(row[j]);
        end
        sum = sum >>> weight_frac;
        if (sum > lim - 1) begin
            sum = lim - 1;
        end else if (sum < -lim) begin
            sum = -lim;
        end
        if ((a == act_relu) && (sum < 0)) begin
            sum = 0;
        end
        return data_t'(sum);
    endfunction

    task automatic build_weights(input int mode);
        int i;
        int j;
        for (i = 0; i < num_neuron; i++) begin
            for (j = 0; j < num_neuron; j++) begin
                case (mode)
                    w_ident: w_mat[i][j] = (i == j) ? weight_t'(1 << weight_frac) : '0;
                    w_rand: begin
                        rng = xorshift32(rng);
                        w_mat[i][j] = {{(weight_w - 8){rng[7]}}, rng[7:0]};
                    end
                    // Even rows push up, odd rows push down
                    default: w_mat[i][j] = (i % 2 == 0) ? weight_t'(32767) : weight_t'(-32768);
                endcase
            end
        end
    endtask

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_vector(input data_t [num_neuron-1:0] got,
                                input data_t [num_neuron-1:0] exp, input string what);
        int i;
        for (i = 0; i < num_neuron; i++) begin
            if (got[i] !== exp[i]) begin
                $display("FAIL @%0t: %s element %0d got %0d expected %0d",
                         $time, what, i, got[i], exp[i]);
                stop_run();
            end
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %b expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("FAIL @%0t: %s got %0d expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (busy !== 1'b0) begin
            if (waited == valid_timeout) begin
                $display("Timeout at %0t: busy never dropped", $time);
                stop_run();
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // Counts on from the cycles already spent since start
    task automatic wait_valid(inout int cycles);
        int waited;
        waited = 0;
        while (final_output_valid !== 1'b1) begin
            if (waited == valid_timeout) begin
                $display("Timeout at %0t: final_output_valid never came", $time);
                stop_run();
            end
            @(negedge clk);
            waited++;
            cycles++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Command runner
    //////////////////////////////////////////////////////////////////////

    task automatic run_command(input int c);
        data_t [num_neuron-1:0] src;
        data_t [num_neuron-1:0] exp;
        int                     cycles;
        int                     i;
        wait_idle();
        build_weights(cmd_table[c][2]);
        for (i = 0; i < num_neuron; i++) begin
            start_input[i] = data_t'(cmd_table[c][5 + i]);
        end
        layer_number = layer_w'(cmd_table[c][0]);
        act          = act_e'(cmd_table[c][1]);
        weights      = w_mat;
        src = (cmd_table[c][0] == 0) ? start_input : model_fb;
        for (i = 0; i < num_neuron; i++) begin
            exp[i] = model_neuron(w_mat[i], src, act);
        end
        model_fb = exp;
        if (cmd_table[c][3] != 0) begin
            for (i = 0; i < num_neuron; i++) begin
                exp[i] = data_t'(exp_table[c][i]);
            end
        end
        start = 1'b1;
        @(negedge clk);
        // Half a cycle past the accepting edge, no full cycle yet
        cycles = 0;
        start  = 1'b0;
        check_bit(busy, 1'b1, "busy after start");
        // Stray start during the run, must be dropped
        if (cmd_table[c][4] != 0) begin
            start        = 1'b1;
            act          = act_linear;
            layer_number = layer_w'(1);
            start_input  = '0;
            @(negedge clk);
            cycles++;
            start = 1'b0;
        end
        wait_valid(cycles);
        check_count(cycles, latency, "start to valid cycles");
        check_vector(final_output, exp, $sformatf("command %0d output", c));
        @(negedge clk);
        check_bit(final_output_valid, 1'b0, "valid pulse width");
        check_bit(busy, 1'b0, "busy after valid");
        if (cmd_table[c][4] != 0) begin
            for (i = 0; i < valid_timeout; i++) begin
                @(negedge clk);
                check_bit(final_output_valid, 1'b0, "extra valid after ignored start");
            end
        end
    endtask

    initial begin
        int c;
        rng          = 32'h9010;
        model_fb     = '0;
        w_mat        = '0;
        arst_n       = 1'b0;
        start        = 1'b0;
        layer_number = '0;
        act          = act_linear;
        start_input  = '0;
        weights      = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(final_output_valid, 1'b0, "valid after reset");
        for (c = 0; c < num_cmd; c++) begin
            run_command(c);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* rtl/nn_forward.sv */
module nn_forward (
    input  logic                                                      clk,
    input  logic                                                      arst_n,
    input  logic                                                      start,
    input  logic [nn_pkg::layer_w-1:0]                                layer_number,
    input  nn_pkg::act_e                                              act,
    input  nn_pkg::data_t [nn_pkg::num_neuron-1:0]                    start_input,
    input  nn_pkg::weight_t [nn_pkg::num_neuron-1:0][nn_pkg::num_neuron-1:0] weights,
    output logic                                                      busy,
    output nn_pkg::data_t [nn_pkg::num_neuron-1:0]                    final_output,
    output logic                                                      final_output_valid
);
    import nn_pkg::*;

    weight_t [num_neuron-1:0][num_neuron-1:0] weight_rows;
    data_t [num_neuron-1:0]                   y;
    logic [num_neuron-1:0]                    y_valid;
    data_t [num_neuron-1:0]                   feedback;

    neuron_bus_if nbus ();

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////////////////////////

    layer_sequencer u_seq (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .layer_number (layer_number),
        .act          (act),
        .start_input  (start_input),
        .weights      (weights),
        .feedback     (feedback),
        .busy         (busy),
        .weight_rows  (weight_rows),
        .bus          (nbus)
    );

    // Neuron bank, one weight row each
    for (genvar i = 0; i < num_neuron; i++) begin : g_neuron
        neuron_mac u_neuron (
            .clk     (clk),
            .arst_n  (arst_n),
            .w_row   (weight_rows[i]),
            .bus     (nbus),
            .y       (y[i]),
            .y_valid (y_valid[i])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Collector
    //////////////////////////////////////////////////////////////////////

    output_collector u_collect (
        .clk                (clk),
        .arst_n             (arst_n),
        .y                  (y),
        .y_valid            (y_valid),
        .final_output       (final_output),
        .final_output_valid (final_output_valid),
        .feedback           (feedback)
    );

endmodule

/* rtl/output_collector.sv */
module output_collector (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  nn_pkg::data_t [nn_pkg::num_neuron-1:0] y,
    input  logic [nn_pkg::num_neuron-1:0]          y_valid,
    output nn_pkg::data_t [nn_pkg::num_neuron-1:0] final_output,
    output logic                                   final_output_valid,
    output nn_pkg::data_t [nn_pkg::num_neuron-1:0] feedback
);
    import nn_pkg::*;

    logic                   all_valid;
    logic                   valid_q;
    data_t [num_neuron-1:0] result_q;

    // Neurons finish together
    assign all_valid = &y_valid;

    //////////////////////////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////////////////////////

    // Feedback must read zero until the first layer completes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_q <= '0;
        end else if (all_valid) begin
            result_q <= y;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= all_valid;
        end
    end

    assign final_output       = result_q;
    assign final_output_valid = valid_q;

    // Same vector feeds the next layer
    assign feedback = result_q;

    a_valid_not_mixed : assert property (
        @(posedge clk) disable iff (!arst_n) (|y_valid) |-> (&y_valid)
    );

endmodule

/* neuron/neuron_mac.sv */
module neuron_mac (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  nn_pkg::weight_t [nn_pkg::num_neuron-1:0] w_row,
    neuron_bus_if.neuron                           bus,
    output nn_pkg::data_t                          y,
    output logic                                   y_valid
);
    import nn_pkg::*;

    weight_t w_sel;
    acc_t    product;
    acc_t    acc;
    acc_t    scaled;
    acc_t    clipped;
    data_t   result;

    //////////////////////////////////////////////////////////////////////
    // Multiply-accumulate
    //////////////////////////////////////////////////////////////////////

    // Weight column follows the broadcast index
    assign w_sel   = w_row[bus.idx];
    assign product = acc_t'(bus.x) * acc_t'(w_sel);

    always_ff @(posedge clk) begin
        if (bus.clear) begin
            acc <= '0;
        end else if (bus.mac_en) begin
            acc <= acc + product;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output stage
    //////////////////////////////////////////////////////////////////////

    // Back to data fraction, rounds toward minus infinity
    assign scaled = acc >>> (prod_frac - data_frac);

    always_comb begin
        if (scaled > data_max) begin
            clipped = data_max;
        end else if (scaled < data_min) begin
            clipped = data_min;
        end else begin
            clipped = scaled;
        end
    end

    // ReLU on the saturated value
    assign result = ((bus.act == act_relu) && clipped[acc_w-1]) ? '0 : data_t'(clipped);

    always_ff @(posedge clk) begin
        if (bus.finish) begin
            y <= result;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            y_valid <= 1'b0;
        end else begin
            y_valid <= bus.finish;
        end
    end

    a_clear_not_mac : assert property (
        @(posedge clk) disable iff (!arst_n) !(bus.clear && bus.mac_en)
    );

endmodule

/* rtl/layer_sequencer.sv */
module layer_sequencer (
    input  logic                                                      clk,
    input  logic                                                      arst_n,
    input  logic                                                      start,
    input  logic [nn_pkg::layer_w-1:0]                                layer_number,
    input  nn_pkg::act_e                                              act,
    input  nn_pkg::data_t [nn_pkg::num_neuron-1:0]                    start_input,
    input  nn_pkg::weight_t [nn_pkg::num_neuron-1:0][nn_pkg::num_neuron-1:0] weights,
    input  nn_pkg::data_t [nn_pkg::num_neuron-1:0]                    feedback,
    output logic                                                      busy,
    output nn_pkg::weight_t [nn_pkg::num_neuron-1:0][nn_pkg::num_neuron-1:0] weight_rows,
    neuron_bus_if.seq                                                 bus
);
    import nn_pkg::*;

    seq_state_e                state;
    logic [idx_w-1:0]          idx;
    logic                      mac_en;
    logic                      finish;
    logic                      accept;
    act_e                      act_q;
    data_t [num_neuron-1:0]    src;

    // Start only counts while idle
    assign accept = start && (state == seq_idle);
    assign busy   = (state != seq_idle);

    //////////////////////////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= seq_idle;
            idx    <= '0;
            mac_en <= 1'b0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            unique case (state)
                seq_idle: begin
                    if (accept) begin
                        state  <= seq_run;
                        idx    <= '0;
                        mac_en <= 1'b1;
                    end
                end
                seq_run: begin
                    if (idx == last_idx) begin
                        state  <= seq_finish;
                        idx    <= '0;
                        mac_en <= 1'b0;
                        finish <= 1'b1;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                seq_finish: begin
                    // Hold busy until the collector has updated feedback
                    if (idx == drain_last) begin
                        state <= seq_idle;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    // Command latch
    always_ff @(posedge clk) begin
        if (accept) begin
            weight_rows <= weights;
            act_q       <= act;
            src         <= (layer_number == '0) ? start_input : feedback;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Broadcast to the neuron bank
    //////////////////////////////////////////////////////////////////////

    // Clear lands on the accept edge, before element 0
    assign bus.clear  = accept;
    assign bus.mac_en = mac_en;
    assign bus.idx    = idx;
    assign bus.x      = src[idx];
    assign bus.act    = act_q;
    assign bus.finish = finish;

    a_mac_en_in_run : assert property (
        @(posedge clk) disable iff (!arst_n) bus.mac_en |-> (state == seq_run)
    );

endmodule

/* common/neuron_bus_if.sv */
interface neuron_bus_if;
    import nn_pkg::*;

    // Accumulator clear, one cycle
    logic             clear;
    // Element strobe
    logic             mac_en;
    // Element index, selects the weight column
    logic [idx_w-1:0] idx;
    data_t            x;
    act_e             act;
    // Rescale and register the neuron outputs
    logic             finish;

    modport seq (
        output clear,
        output mac_en,
        output idx,
        output x,
        output act,
        output finish
    );

    modport neuron (
        input clear,
        input mac_en,
        input idx,
        input x,
        input act,
        input finish
    );

endinterface

/* common/nn_pkg.sv */
package nn_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////

    // Neuron count, also the vector length
    localparam int unsigned num_neuron = 7;
    localparam int unsigned idx_w      = 3;
    localparam int unsigned layer_w    = 2;

    // Fixed-point formats
    localparam int unsigned data_w      = 9;
    localparam int unsigned data_frac   = 8;
    localparam int unsigned weight_w    = 17;
    localparam int unsigned weight_frac = 8;

    // Fraction bits of a data by weight product
    localparam int unsigned prod_frac = data_frac + weight_frac;

    // Seven 26-bit products fit in 29 bits
    localparam int unsigned acc_w = 30;

    typedef logic signed [data_w-1:0]   data_t;
    typedef logic signed [weight_w-1:0] weight_t;
    typedef logic signed [acc_w-1:0]    acc_t;

    // Saturation bounds in accumulator width
    localparam acc_t data_max = acc_t'((2 ** (data_w - 1)) - 1);
    localparam acc_t data_min = acc_t'(-(2 ** (data_w - 1)));

    // Sequencer counter limits
    localparam logic [idx_w-1:0] last_idx = idx_w'(num_neuron - 1);
    // Finish plus neuron and collector register stages
    localparam logic [idx_w-1:0] drain_last = idx_w'(2);

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {
        act_linear,
        act_relu
    } act_e;

    typedef enum logic [1:0] {
        seq_idle,
        seq_run,
        seq_finish
    } seq_state_e;

endpackage
